/* common/bmem_pkg.sv */
`default_nettype none

package bmem_pkg;

    // Byte address on both the cache side and the memory side
    localparam int ADDR_W = 32;

    // One memory beat
    localparam int BEAT_W = 64;

    // One cache line
    localparam int LINE_W = 256;

    // Beats needed to move one line
    localparam int BURST_BEATS = LINE_W / BEAT_W;

    // A line seen either as one word or as its memory beats.
    // Beat 0 sits in the least significant bits.
    typedef union packed {
        logic [LINE_W-1:0]                  word;
        logic [BURST_BEATS-1:0][BEAT_W-1:0] beats;
    } line_u;

endpackage

`default_nettype wire

/* common/arb_pkg.sv */
`default_nettype none

package arb_pkg;

    // Source numbers, also used as pending slot index
    localparam logic SRC_INST = 1'b0;
    localparam logic SRC_DATA = 1'b1;

    localparam int NUM_SRC = 2;

    // Counts beats within one burst
    localparam int BEAT_CNT_W = 2;

    // Index of the final beat of a burst
    localparam logic [BEAT_CNT_W-1:0] LAST_BEAT_IDX =
        BEAT_CNT_W'(bmem_pkg::BURST_BEATS - 1);

endpackage

`default_nettype wire

/* hw/cache_arbiter/request_select.sv */
`default_nettype none

module request_select (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [bmem_pkg::ADDR_W-1:0]       inst_addr,
    input  logic                              inst_read,
    input  logic [bmem_pkg::ADDR_W-1:0]       data_addr,
    input  logic                              data_read,
    input  logic                              data_write,
    input  logic [bmem_pkg::LINE_W-1:0]       data_wdata,
    input  logic [arb_pkg::NUM_SRC-1:0]       src_busy,
    output logic [bmem_pkg::ADDR_W-1:0]       bmem_addr,
    output logic                              bmem_read,
    output logic                              bmem_write,
    output logic [bmem_pkg::BEAT_W-1:0]       bmem_wdata,
    output logic                              issue_valid,
    output logic                              issue_src,
    output logic [bmem_pkg::ADDR_W-1:0]       issue_addr,
    output logic                              wr_done
);

    logic                             inst_new;
    logic                             data_new;
    logic                             data_go;
    logic                             wr_start;
    logic                             data_deferred;
    logic                             wr_active;
    logic [arb_pkg::BEAT_CNT_W-1:0]   wr_cnt;
    logic [arb_pkg::BEAT_CNT_W-1:0]   beat_idx;
    bmem_pkg::line_u                  wline;

    // A request counts as new only when nothing of its own is outstanding
    assign inst_new = inst_read && !src_busy[arb_pkg::SRC_INST] && !wr_active && !data_deferred;
    assign data_new = (data_read || data_write) && !src_busy[arb_pkg::SRC_DATA]
                      && !wr_active && !data_deferred;

    // Data goes now if it was held back last cycle or has no competitor
    assign data_go  = data_deferred || (data_new && !inst_new);
    assign wr_start = data_go && data_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_deferred <= 1'b0;
            wr_active     <= 1'b0;
            wr_cnt        <= '0;
        end else begin
            // Lost a tie, so it goes out next cycle
            data_deferred <= inst_new && data_new;
            if (wr_start) begin
                wr_active <= 1'b1;
                wr_cnt    <= (arb_pkg::BEAT_CNT_W)'(1);
            end else if (wr_active) begin
                wr_cnt <= wr_cnt + (arb_pkg::BEAT_CNT_W)'(1);
                if (wr_cnt == arb_pkg::LAST_BEAT_IDX) begin
                    wr_active <= 1'b0;
                end
            end
        end
    end

    // Beat 0 leaves in the start cycle, the rest follow from the counter
    assign wline.word = data_wdata;
    assign beat_idx   = wr_active ? wr_cnt : '0;
    assign bmem_wdata = wline.beats[beat_idx];
    assign wr_done    = wr_active && (wr_cnt == arb_pkg::LAST_BEAT_IDX);

    always_comb begin
        bmem_addr  = inst_addr;
        bmem_read  = 1'b0;
        bmem_write = 1'b0;
        issue_src  = arb_pkg::SRC_INST;
        if (wr_active) begin
            bmem_addr  = data_addr;
            bmem_write = 1'b1;
        end else if (data_go) begin
            bmem_addr  = data_addr;
            bmem_read  = data_read;
            bmem_write = data_write;
            issue_src  = arb_pkg::SRC_DATA;
        end else if (inst_new) begin
            bmem_read = 1'b1;
        end
    end

    // Only reads need a pending slot
    assign issue_valid = bmem_read;
    assign issue_addr  = bmem_addr;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read && bmem_write));

    // The losing data request must reach memory one cycle later
    a_defer_next: assert property (@(posedge clk) disable iff (rst)
        (inst_new && data_new) |=> ((bmem_read || bmem_write) && bmem_addr == data_addr));

endmodule

`default_nettype wire

/* hw/cache_arbiter/pending_table.sv */
`default_nettype none

module pending_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue_valid,
    input  logic                          issue_src,
    input  logic [bmem_pkg::ADDR_W-1:0]   issue_addr,
    input  logic                          last_beat,
    input  logic [bmem_pkg::ADDR_W-1:0]   beat_raddr,
    output logic [arb_pkg::NUM_SRC-1:0]   src_busy,
    output logic                          hit_valid,
    output logic                          hit_src
);

    // One slot per source, each side has at most one read in flight
    logic [arb_pkg::NUM_SRC-1:0]  slot_valid;
    logic [bmem_pkg::ADDR_W-1:0]  slot_addr [arb_pkg::NUM_SRC];
    logic [arb_pkg::NUM_SRC-1:0]  slot_match;

    always_comb begin
        for (int i = 0; i < arb_pkg::NUM_SRC; i++) begin
            slot_match[i] = slot_valid[i] && (slot_addr[i] == beat_raddr);
        end
    end

    // Only the final beat of a line completes a read
    assign hit_valid = last_beat && (|slot_match);
    assign hit_src   = slot_match[arb_pkg::SRC_INST] ? arb_pkg::SRC_INST : arb_pkg::SRC_DATA;

    assign src_busy = slot_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
        end else begin
            if (hit_valid) begin
                slot_valid[hit_src] <= 1'b0;
            end
            // Issue and retire never hit the same slot
            if (issue_valid) begin
                slot_valid[issue_src] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            slot_addr[issue_src] <= issue_addr;
        end
    end

    a_issue_free: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !slot_valid[issue_src]);

    // Every returning line must belong to exactly one outstanding read
    a_last_match: assert property (@(posedge clk) disable iff (rst)
        last_beat |-> $onehot(slot_match));

endmodule

`default_nettype wire

/* hw/cache_arbiter/line_assembler.sv */
`default_nettype none

module line_assembler (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          bmem_rvalid,
    input  logic [bmem_pkg::ADDR_W-1:0]   bmem_raddr,
    input  logic [bmem_pkg::BEAT_W-1:0]   bmem_rdata,
    input  logic                          hit_valid,
    input  logic                          hit_src,
    input  logic                          wr_done,
    output logic                          last_beat,
    output logic [bmem_pkg::ADDR_W-1:0]   beat_raddr,
    output logic [bmem_pkg::LINE_W-1:0]   inst_rdata,
    output logic                          inst_resp,
    output logic [bmem_pkg::LINE_W-1:0]   data_rdata,
    output logic                          data_resp
);

    logic [arb_pkg::BEAT_CNT_W-1:0]  beat_cnt;
    logic [bmem_pkg::BEAT_W-1:0]     beat_buf [bmem_pkg::BURST_BEATS-1];
    bmem_pkg::line_u                 line;

    // Lines never interleave, so one counter tracks the current burst
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (bmem_rvalid) begin
            beat_cnt <= beat_cnt + (arb_pkg::BEAT_CNT_W)'(1);
        end
    end

    // The last beat is forwarded, so only the first three are stored
    always_ff @(posedge clk) begin
        if (bmem_rvalid && beat_cnt != arb_pkg::LAST_BEAT_IDX) begin
            beat_buf[beat_cnt] <= bmem_rdata;
        end
    end

    assign last_beat  = bmem_rvalid && (beat_cnt == arb_pkg::LAST_BEAT_IDX);
    assign beat_raddr = bmem_raddr;

    always_comb begin
        for (int i = 0; i < bmem_pkg::BURST_BEATS - 1; i++) begin
            line.beats[i] = beat_buf[i];
        end
        line.beats[bmem_pkg::BURST_BEATS-1] = bmem_rdata;
    end

    // Both sides see the line, the resp pulse tells who owns it
    assign inst_rdata = line.word;
    assign data_rdata = line.word;
    assign inst_resp  = hit_valid && (hit_src == arb_pkg::SRC_INST);
    assign data_resp  = (hit_valid && (hit_src == arb_pkg::SRC_DATA)) || wr_done;

    // Data side cannot have a read and a write finishing together
    a_data_resp_once: assert property (@(posedge clk) disable iff (rst)
        !(hit_valid && hit_src == arb_pkg::SRC_DATA && wr_done));

endmodule

`default_nettype wire

/* hw/cache_arbiter/cache_arbiter.sv */
`default_nettype none

module cache_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [bmem_pkg::ADDR_W-1:0]   inst_addr,
    input  logic                          inst_read,
    output logic [bmem_pkg::LINE_W-1:0]   inst_rdata,
    output logic                          inst_resp,
    input  logic [bmem_pkg::ADDR_W-1:0]   data_addr,
    input  logic                          data_read,
    input  logic                          data_write,
    input  logic [bmem_pkg::LINE_W-1:0]   data_wdata,
    output logic [bmem_pkg::LINE_W-1:0]   data_rdata,
    output logic                          data_resp,
    output logic [bmem_pkg::ADDR_W-1:0]   bmem_addr,
    output logic                          bmem_read,
    output logic                          bmem_write,
    output logic [bmem_pkg::BEAT_W-1:0]   bmem_wdata,
    input  logic                          bmem_rvalid,
    input  logic [bmem_pkg::ADDR_W-1:0]   bmem_raddr,
    input  logic [bmem_pkg::BEAT_W-1:0]   bmem_rdata
);

    logic [arb_pkg::NUM_SRC-1:0]  src_busy;
    logic                         issue_valid;
    logic                         issue_src;
    logic [bmem_pkg::ADDR_W-1:0]  issue_addr;
    logic                         wr_done;
    logic                         last_beat;
    logic [bmem_pkg::ADDR_W-1:0]  beat_raddr;
    logic                         hit_valid;
    logic                         hit_src;

    request_select u_request_select (
        .clk        (clk),
        .rst        (rst),
        .inst_addr  (inst_addr),
        .inst_read  (inst_read),
        .data_addr  (data_addr),
        .data_read  (data_read),
        .data_write (data_write),
        .data_wdata (data_wdata),
        .src_busy   (src_busy),
        .bmem_addr  (bmem_addr),
        .bmem_read  (bmem_read),
        .bmem_write (bmem_write),
        .bmem_wdata (bmem_wdata),
        .issue_valid(issue_valid),
        .issue_src  (issue_src),
        .issue_addr (issue_addr),
        .wr_done    (wr_done)
    );

    pending_table u_pending_table (
        .clk        (clk),
        .rst        (rst),
        .issue_valid(issue_valid),
        .issue_src  (issue_src),
        .issue_addr (issue_addr),
        .last_beat  (last_beat),
        .beat_raddr (beat_raddr),
        .src_busy   (src_busy),
        .hit_valid  (hit_valid),
        .hit_src    (hit_src)
    );

    line_assembler u_line_assembler (
        .clk        (clk),
        .rst        (rst),
        .bmem_rvalid(bmem_rvalid),
        .bmem_raddr (bmem_raddr),
        .bmem_rdata (bmem_rdata),
        .hit_valid  (hit_valid),
        .hit_src    (hit_src),
        .wr_done    (wr_done),
        .last_beat  (last_beat),
        .beat_raddr (beat_raddr),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .data_rdata (data_rdata),
        .data_resp  (data_resp)
    );

endmodule

`default_nettype wire

/* dv/arb_monitor.sv */
`default_nettype none

module arb_monitor (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [bmem_pkg::ADDR_W-1:0]   inst_addr,
    input  logic                          inst_read,
    input  logic [bmem_pkg::LINE_W-1:0]   inst_rdata,
    input  logic                          inst_resp,
    input  logic [bmem_pkg::ADDR_W-1:0]   data_addr,
    input  logic                          data_read,
    input  logic                          data_write,
    input  logic [bmem_pkg::LINE_W-1:0]   data_wdata,
    input  logic [bmem_pkg::LINE_W-1:0]   data_rdata,
    input  logic                          data_resp,
    input  logic [bmem_pkg::ADDR_W-1:0]   bmem_addr,
    input  logic                          bmem_read,
    input  logic                          bmem_write,
    input  logic [bmem_pkg::BEAT_W-1:0]   bmem_wdata,
    input  logic                          test_end,
    input  int                            test_id,
    input  int                            exp_inst,
    input  int                            exp_data,
    output int                            err_total,
    output int                            tests_failed,
    output int                            tests_passed
);

    logic [bmem_pkg::LINE_W-1:0]  model [logic [bmem_pkg::ADDR_W-1:0]];
    bmem_pkg::line_u              wline;
    logic [bmem_pkg::LINE_W-1:0]  exp_line;
    logic                         i_issued;
    logic                         d_issued;
    logic                         tie_next;
    logic [2:0]                   wcount;
    int                           test_errs;
    int                           inst_seen;
    int                           data_seen;

    // Line contents the caches should read back
    function automatic logic [bmem_pkg::LINE_W-1:0] expected_line(
        input logic [bmem_pkg::ADDR_W-1:0] addr);
        bmem_pkg::line_u l;
        if (model.exists(addr)) begin
            l.word = model[addr];
        end else begin
            for (int k = 0; k < bmem_pkg::BURST_BEATS; k++) begin
                l.beats[k] = {addr, addr ^ 32'(k)};
            end
        end
        return l.word;
    endfunction

    task automatic count_error();
        test_errs++;
        err_total++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            i_issued = 1'b0;
            d_issued = 1'b0;
            tie_next = 1'b0;
            wcount = '0;
            test_errs = 0;
            inst_seen = 0;
            data_seen = 0;
            err_total = 0;
            tests_failed = 0;
            tests_passed = 0;
        end else begin
            // Data side lost the tie last cycle
            if (tie_next && !((bmem_read || bmem_write) && bmem_addr == data_addr)) begin
                $display("test %0d: data request did not reach memory after the tie", test_id);
                count_error();
            end
            tie_next = 1'b0;
            if (bmem_read) begin
                if (inst_read && !i_issued && bmem_addr == inst_addr) begin
                    tie_next = (data_read || data_write) && !d_issued;
                    i_issued = 1'b1;
                end else if (data_read && !d_issued && bmem_addr == data_addr) begin
                    d_issued = 1'b1;
                    // Instruction side wins a tie, so it cannot still be waiting here
                    if (inst_read && !i_issued) begin
                        $display("test %0d: data read went to memory before the instruction read",
                                 test_id);
                        count_error();
                    end
                end else begin
                    $display("test %0d: memory read of %h has no waiting request",
                             test_id, bmem_addr);
                    count_error();
                end
            end
            if (bmem_write) begin
                wline.word = data_wdata;
                d_issued = 1'b1;
                if (!data_write) begin
                    $display("test %0d: memory write without a data write request", test_id);
                    count_error();
                end else if (bmem_addr != data_addr) begin
                    $display("[ERROR] test %0d bmem_addr expected %h got %h",
                             test_id, data_addr, bmem_addr);
                    count_error();
                end else if (bmem_wdata != wline.beats[wcount[1:0]]) begin
                    $display("[ERROR] test %0d bmem_wdata beat %0d expected %h got %h",
                             test_id, wcount, wline.beats[wcount[1:0]], bmem_wdata);
                    count_error();
                end
                wcount++;
            end
            if (inst_resp) begin
                inst_seen++;
                exp_line = expected_line(inst_addr);
                i_issued = 1'b0;
                if (!inst_read) begin
                    $display("test %0d: inst_resp pulsed with no instruction request", test_id);
                    count_error();
                end else if (inst_rdata != exp_line) begin
                    $display("[ERROR] test %0d inst_rdata expected %h got %h",
                             test_id, exp_line, inst_rdata);
                    count_error();
                end
            end
            if (data_resp) begin
                data_seen++;
                exp_line = expected_line(data_addr);
                d_issued = 1'b0;
                if (data_write) begin
                    if (wcount != 3'd4) begin
                        $display("test %0d: write answered after %0d beats", test_id, wcount);
                        count_error();
                    end
                    model[data_addr] = data_wdata;
                    wcount = '0;
                end else if (!data_read) begin
                    $display("test %0d: data_resp pulsed with no data request", test_id);
                    count_error();
                end else if (data_rdata != exp_line) begin
                    $display("[ERROR] test %0d data_rdata expected %h got %h",
                             test_id, exp_line, data_rdata);
                    count_error();
                end
            end
            if (test_end) begin
                if (inst_seen != exp_inst || data_seen != exp_data) begin
                    $display("test %0d: wanted %0d inst and %0d data responses, saw %0d and %0d",
                             test_id, exp_inst, exp_data, inst_seen, data_seen);
                    count_error();
                end
                if (test_errs == 0) begin
                    tests_passed++;
                    $display("test %0d passed", test_id);
                end else begin
                    tests_failed++;
                    $display("test %0d failed with %0d errors", test_id, test_errs);
                end
                test_errs = 0;
                inst_seen = 0;
                data_seen = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_cache_arbiter.sv */
`default_nettype none

module tb_cache_arbiter;

    localparam int NUM_ROWS    = 8;
    localparam int MAX_LAT     = 20;
    // Worst latency for every row, plus reset and the idle gaps
    localparam int CYCLE_LIMIT = NUM_ROWS * (MAX_LAT + 40) + 100;

    localparam logic [2:0] OP_IDLE  = 3'd0;
    localparam logic [2:0] OP_INST  = 3'd1;
    localparam logic [2:0] OP_DATA  = 3'd2;
    localparam logic [2:0] OP_BOTH  = 3'd3;
    localparam logic [2:0] OP_WRITE = 3'd4;

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] iaddr;
        logic [31:0] daddr;
        logic [31:0] seed;
        int          ilat;
        int          dlat;
    } row_t;

    logic                          clk = 1'b0;
    logic                          rst = 1'b1;
    logic [bmem_pkg::ADDR_W-1:0]   inst_addr;
    logic                          inst_read;
    logic [bmem_pkg::LINE_W-1:0]   inst_rdata;
    logic                          inst_resp;
    logic [bmem_pkg::ADDR_W-1:0]   data_addr;
    logic                          data_read;
    logic                          data_write;
    logic [bmem_pkg::LINE_W-1:0]   data_wdata;
    logic [bmem_pkg::LINE_W-1:0]   data_rdata;
    logic                          data_resp;
    logic [bmem_pkg::ADDR_W-1:0]   bmem_addr;
    logic                          bmem_read;
    logic                          bmem_write;
    logic [bmem_pkg::BEAT_W-1:0]   bmem_wdata;
    logic                          bmem_rvalid = 1'b0;
    logic [bmem_pkg::ADDR_W-1:0]   bmem_raddr = '0;
    logic [bmem_pkg::BEAT_W-1:0]   bmem_rdata = '0;
    logic                          test_end;
    int                            test_id;
    int                            exp_inst;
    int                            exp_data;
    int                            err_total;
    int                            tests_failed;
    int                            tests_passed;

    row_t                          rows [NUM_ROWS];
    int                            row_idx;
    int                            cycle = 0;
    logic [31:0]                   lfsr_state;
    logic [bmem_pkg::LINE_W-1:0]   mem_lines [logic [bmem_pkg::ADDR_W-1:0]];
    logic [bmem_pkg::ADDR_W-1:0]   rq_addr [$];
    int                            rq_ready [$];
    logic [bmem_pkg::ADDR_W-1:0]   burst_addr;
    logic                          burst_on;
    logic [1:0]                    burst_beat;
    logic [1:0]                    wr_beat;

    cache_arbiter DUT (.*);

    arb_monitor monitor (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the tests", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [bmem_pkg::LINE_W-1:0] make_line(input logic [31:0] pat);
        logic [bmem_pkg::LINE_W-1:0] l;
        for (int b = 0; b < bmem_pkg::LINE_W; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            l[b]       = lfsr_state[0];
        end
        return l ^ {8{pat}};
    endfunction

    function automatic int read_latency(input logic [bmem_pkg::ADDR_W-1:0] addr);
        return (addr == rows[row_idx].iaddr) ? rows[row_idx].ilat : rows[row_idx].dlat;
    endfunction

    // Untouched lines read back as address and address xor beat
    function automatic logic [bmem_pkg::BEAT_W-1:0] memory_beat(
        input logic [bmem_pkg::ADDR_W-1:0] addr, input logic [1:0] k);
        bmem_pkg::line_u l;
        if (mem_lines.exists(addr)) begin
            l.word = mem_lines[addr];
            return l.beats[k];
        end
        return {addr, addr ^ {30'd0, k}};
    endfunction

    task automatic store_beat(input logic [bmem_pkg::ADDR_W-1:0] addr, input logic [1:0] k,
                              input logic [bmem_pkg::BEAT_W-1:0] beat);
        bmem_pkg::line_u l;
        l.word          = mem_lines.exists(addr) ? mem_lines[addr] : '0;
        l.beats[k]      = beat;
        mem_lines[addr] = l.word;
    endtask

    // Oldest ready read goes first, whole line at a time
    task automatic start_burst();
        int pick;
        pick = -1;
        for (int i = 0; i < rq_addr.size(); i++) begin
            if (rq_ready[i] <= cycle && (pick < 0 || rq_ready[i] < rq_ready[pick])) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            burst_addr = rq_addr[pick];
            burst_on   = 1'b1;
            burst_beat = '0;
            rq_addr.delete(pick);
            rq_ready.delete(pick);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            bmem_rvalid <= 1'b0;
            burst_on = 1'b0;
            burst_beat = '0;
            wr_beat = '0;
            rq_addr.delete();
            rq_ready.delete();
        end else begin
            if (bmem_write) begin
                store_beat(bmem_addr, wr_beat, bmem_wdata);
                wr_beat = wr_beat + 2'd1;
            end
            if (bmem_read) begin
                rq_addr.push_back(bmem_addr);
                rq_ready.push_back(cycle + read_latency(bmem_addr));
            end
            if (!burst_on) begin
                start_burst();
            end
            bmem_rvalid <= burst_on;
            if (burst_on) begin
                bmem_raddr <= burst_addr;
                bmem_rdata <= memory_beat(burst_addr, burst_beat);
                burst_on = (burst_beat != 2'd3);
                burst_beat = burst_beat + 2'd1;
            end
        end
    end

    task automatic run_row(input int n);
        row_t r;
        logic want_i;
        logic want_d;
        int   waited;
        r       = rows[n];
        want_i  = (r.op == OP_INST) || (r.op == OP_BOTH);
        want_d  = (r.op == OP_DATA) || (r.op == OP_BOTH) || (r.op == OP_WRITE);
        row_idx = n;
        @(posedge clk);
        test_id  <= n;
        exp_inst <= int'(want_i);
        exp_data <= int'(want_d);
        if (want_i) begin
            inst_addr <= r.iaddr;
            inst_read <= 1'b1;
        end
        if (want_d) begin
            data_addr  <= r.daddr;
            data_wdata <= (r.op == OP_WRITE) ? make_line(r.seed) : '0;
            data_read  <= (r.op != OP_WRITE);
            data_write <= (r.op == OP_WRITE);
        end
        waited = 0;
        while ((want_i || want_d || r.op == OP_IDLE) && waited < r.ilat + r.dlat + 30) begin
            @(posedge clk);
            waited++;
            if (inst_resp && want_i) begin
                inst_read <= 1'b0;
                want_i = 1'b0;
            end
            if (data_resp && want_d) begin
                data_read  <= 1'b0;
                data_write <= 1'b0;
                want_d = 1'b0;
            end
        end
        inst_read  <= 1'b0;
        data_read  <= 1'b0;
        data_write <= 1'b0;
        repeat (3) @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        inst_addr  = '0;
        inst_read  = 1'b0;
        data_addr  = '0;
        data_read  = 1'b0;
        data_write = 1'b0;
        data_wdata = '0;
        test_end   = 1'b0;
        test_id    = 0;
        exp_inst   = 0;
        exp_data   = 0;
        row_idx    = 0;
        lfsr_state = 32'hbffa_7c0b;
        // op, inst addr, data addr, write seed, inst latency, data latency
        rows[0] = '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1, 1};
        rows[1] = '{OP_INST,  32'h0000_1000, 32'h0000_0000, 32'h0000_0000, 5, 1};
        rows[2] = '{OP_DATA,  32'h0000_0000, 32'h0000_2040, 32'h0000_0000, 1, 3};
        rows[3] = '{OP_BOTH,  32'h0000_3000, 32'h0000_4020, 32'h0000_0000, 4, 4};
        rows[4] = '{OP_BOTH,  32'h0000_5000, 32'h0000_6000, 32'h0000_0000, 20, 2};
        rows[5] = '{OP_WRITE, 32'h0000_0000, 32'h0000_7000, 32'h5a5a_0f0f, 1, 1};
        rows[6] = '{OP_DATA,  32'h0000_0000, 32'h0000_7000, 32'h0000_0000, 1, 6};
        rows[7] = '{OP_BOTH,  32'h0000_7000, 32'h0000_8000, 32'h0000_0000, 2, 9};
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        $display("Done: %0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, err_total);
        if (err_total == 0 && tests_failed == 0 && tests_passed == NUM_ROWS) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/bmem_pkg.sv
common/arb_pkg.sv
hw/cache_arbiter/request_select.sv
hw/cache_arbiter/pending_table.sv
hw/cache_arbiter/line_assembler.sv
hw/cache_arbiter/cache_arbiter.sv
dv/arb_monitor.sv
dv/tb_cache_arbiter.sv

/* Makefile */
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	verilator --binary --timing --assert --top-module tb_cache_arbiter \
		-f verilog.f --Mdir $(BUILD) -o tb_cache_arbiter
	./$(BUILD)/tb_cache_arbiter | tee $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
